// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := window_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+source
+incdir+testbench
source/window_pkg.sv
source/window_regs.sv
source/window_coeff_ram.sv
source/window_mult.sv
source/window_block.sv
testbench/window_tb.sv

// File: source/window_block.sv
/* Streaming window block on ce_clk.
   Coefficients must be loaded before samples are sent.
   Window framing comes only from the programmed length */
`timescale 1ns/1ps

module window_block (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  // Settings bus and readback
  input  window_pkg::set_bus_t  i_set,
  output window_pkg::rb_data_t  o_rb_data,
  // Coefficient load, always accepted
  input  window_pkg::cfg_beat_t i_cfg,
  input  logic                  i_cfg_valid,
  // Sample input
  input  window_pkg::iq_t       i_sample,
  input  logic                  i_valid,
  output logic                  o_ready,
  // Windowed output
  output window_pkg::iq_t       o_sample,
  output logic                  o_last,
  output logic                  o_valid,
  input  logic                  i_ready
);

  window_pkg::win_len_t win_len;
  logic                 win_len_changed;
  logic                 rd_en;
  window_pkg::win_idx_t rd_addr;
  window_pkg::coeff_t   coeff;

  window_regs reg0 (
    .i_clk             (ce_clk),
    .i_rst             (i_rst),
    .i_set             (i_set),
    .o_win_len         (win_len),
    .o_win_len_changed (win_len_changed),
    .o_rb_data         (o_rb_data)
  );

  window_coeff_ram ram0 (
    .i_clk       (ce_clk),
    .i_rst       (i_rst),
    .i_cfg       (i_cfg),
    .i_cfg_valid (i_cfg_valid),
    .i_rd_en     (rd_en),
    .i_rd_addr   (rd_addr),
    .o_coeff     (coeff)
  );

  window_mult mult0 (
    .i_clk             (ce_clk),
    .i_rst             (i_rst),
    .i_win_len         (win_len),
    .i_win_len_changed (win_len_changed),
    .i_sample          (i_sample),
    .i_valid           (i_valid),
    .o_ready           (o_ready),
    .o_rd_en           (rd_en),
    .o_rd_addr         (rd_addr),
    .i_coeff           (coeff),
    .o_sample          (o_sample),
    .o_last            (o_last),
    .o_valid           (o_valid),
    .i_ready           (i_ready)
  );

endmodule

// File: source/window_coeff_ram.sv
/* Coefficient memory, not reset, so load it before sending samples.
   A load of MAX_WINDOW_SIZE beats must end with last */
`timescale 1ns/1ps
`include "window_settings.svh"

module window_coeff_ram (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  window_pkg::cfg_beat_t i_cfg,
  input  logic                  i_cfg_valid,
  input  logic                  i_rd_en,
  input  window_pkg::win_idx_t  i_rd_addr,
  output window_pkg::coeff_t    o_coeff
);

  localparam window_pkg::win_len_t MAX_LEN = window_pkg::win_len_t'(`MAX_WINDOW_SIZE);

  window_pkg::coeff_t   mem [`MAX_WINDOW_SIZE];

  // One bit wider than the address so an overrun is visible
  window_pkg::win_len_t wr_ptr;
  window_pkg::win_idx_t wr_addr;

  assign wr_addr = window_pkg::win_idx_t'(wr_ptr);

  //////////////////////////////
  // Write pointer
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
    end else if (i_cfg_valid) begin
      if (i_cfg.last) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Memory
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_cfg_valid) begin
      mem[wr_addr] <= i_cfg.coeff;
    end
  end

  // Read register holds while the multiplier is stalled
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_coeff <= mem[i_rd_addr];
    end
  end

  // A load longer than the memory would wrap onto earlier entries
  a_wr_ptr_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cfg_valid |-> wr_ptr < MAX_LEN)
    else $error("coefficient load overruns the memory");

endmodule

// File: source/window_mult.sv
/* Two stage window multiplier with one sample per cycle throughput.
   The sample accepted in the cycle of a length change gets index 0.
   Products are truncated, no rounding and no saturation */
`timescale 1ns/1ps

module window_mult (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  window_pkg::win_len_t i_win_len,
  input  logic                 i_win_len_changed,
  input  window_pkg::iq_t      i_sample,
  input  logic                 i_valid,
  output logic                 o_ready,
  output logic                 o_rd_en,
  output window_pkg::win_idx_t o_rd_addr,
  input  window_pkg::coeff_t   i_coeff,
  output window_pkg::iq_t      o_sample,
  output logic                 o_last,
  output logic                 o_valid,
  input  logic                 i_ready
);

  window_pkg::win_idx_t idx;
  window_pkg::win_idx_t cur_idx;
  window_pkg::win_len_t len_m1;
  logic                 at_end;
  logic                 accept;
  logic                 s2_free;
  logic                 s1_move;

  // Stage one holds the sample while its coefficient is read
  window_pkg::iq_t      s1_sample;
  logic                 s1_last;
  logic                 s1_valid;

  // Q1.15 scale, keeps bits 30:15 of the full product
  function automatic logic signed [15:0] apply_coeff(logic signed [15:0] x,
                                                     window_pkg::coeff_t c);
    logic signed [31:0] p;
    p = x * c;
    return p[30:15];
  endfunction

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign s2_free = !o_valid || i_ready;
  assign s1_move = s1_valid && s2_free;
  assign o_ready = !s1_valid || s2_free;
  assign accept  = i_valid && o_ready;

  //////////////////////////////
  // Window index
  //////////////////////////////

  assign cur_idx = i_win_len_changed ? '0 : idx;
  assign len_m1  = i_win_len - window_pkg::win_len_t'(1);
  assign at_end  = ({1'b0, cur_idx} == len_m1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      idx <= '0;
    end else if (accept) begin
      idx <= at_end ? '0 : cur_idx + 1'b1;
    end else if (i_win_len_changed) begin
      idx <= '0;
    end
  end

  // Coefficient arrives while the sample sits in stage one
  assign o_rd_en   = accept;
  assign o_rd_addr = cur_idx;

  //////////////////////////////
  // Pipeline control
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      o_valid  <= 1'b0;
      o_last   <= 1'b0;
    end else begin
      if (accept) begin
        s1_valid <= 1'b1;
        s1_last  <= at_end;
      end else if (s1_move) begin
        s1_valid <= 1'b0;
      end
      if (s2_free) begin
        o_valid <= s1_valid;
        if (s1_valid) begin
          o_last <= s1_last;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      s1_sample <= i_sample;
    end
    if (s1_move) begin
      o_sample.i <= apply_coeff(s1_sample.i, i_coeff);
      o_sample.q <= apply_coeff(s1_sample.q, i_coeff);
    end
  end

  a_out_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable(o_sample) && $stable(o_last))
    else $error("output changed while stalled");

  // Length comes from the register block, index from this counter
  a_idx_range: assert property (@(posedge i_clk) disable iff (i_rst)
    {1'b0, cur_idx} < i_win_len)
    else $error("window index not below window length");

endmodule

// File: source/window_pkg.sv
/* Shared types of the window block.
   Index and length widths follow MAX_LOG2_WINDOW */
`include "window_settings.svh"

package window_pkg;

  // Q1.15 window coefficient
  typedef logic signed [15:0] coeff_t;

  // Position within a window, 0 to MAX_WINDOW_SIZE-1
  typedef logic [`MAX_LOG2_WINDOW-1:0] win_idx_t;

  // Window length, 1 to MAX_WINDOW_SIZE
  typedef logic [`MAX_LOG2_WINDOW:0] win_len_t;

  typedef logic [63:0] rb_data_t;
  typedef logic [2:0] rb_addr_t;

  // Complex sample, i in the upper half
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq_t;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // One beat of the coefficient load stream
  typedef struct packed {
    coeff_t coeff;
    logic   last;
  } cfg_beat_t;

endpackage

// File: source/window_regs.sv
/* Window length and readback select from the settings bus.
   A length of 0, or one above MAX_WINDOW_SIZE, is stored as MAX_WINDOW_SIZE */
`timescale 1ns/1ps
`include "window_settings.svh"

module window_regs (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  window_pkg::set_bus_t  i_set,
  output window_pkg::win_len_t  o_win_len,
  output logic                  o_win_len_changed,
  output window_pkg::rb_data_t  o_rb_data
);

  localparam window_pkg::win_len_t MAX_LEN = window_pkg::win_len_t'(`MAX_WINDOW_SIZE);

  window_pkg::win_len_t win_len;
  window_pkg::win_len_t wr_len;
  window_pkg::rb_addr_t rb_addr;
  logic                 wr_len_stb;
  logic                 wr_rb_stb;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign wr_len_stb = i_set.stb && (i_set.addr == `SR_WINDOW_SIZE);
  assign wr_rb_stb  = i_set.stb && (i_set.addr == `SR_READBACK);

  // Written length before the range fixup
  assign wr_len = i_set.data[`MAX_LOG2_WINDOW:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      win_len           <= MAX_LEN;
      rb_addr           <= '0;
      o_win_len_changed <= 1'b0;
    end else begin
      o_win_len_changed <= wr_len_stb;
      if (wr_len_stb) begin
        // Zero and oversize both mean a full window
        if (wr_len == '0 || wr_len > MAX_LEN) begin
          win_len <= MAX_LEN;
        end else begin
          win_len <= wr_len;
        end
      end
      if (wr_rb_stb) begin
        rb_addr <= window_pkg::rb_addr_t'(i_set.data);
      end
    end
  end

  assign o_win_len = win_len;

  //////////////////////////////
  // Readback
  //////////////////////////////

  always_comb begin
    case (rb_addr)
      3'd0:    o_rb_data = 64'(`MAX_WINDOW_SIZE);
      3'd1:    o_rb_data = {51'd0, win_len};
      default: o_rb_data = `RB_DEFAULT;
    endcase
  end

  // Downstream index restart relies on a pulse with every new length
  a_len_change_pulsed: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_win_len != $past(o_win_len)) |-> o_win_len_changed)
    else $error("window length changed without the changed pulse");

endmodule

// File: source/window_settings.svh
/* Settings bus addresses and size limits of the window block.
   MAX_WINDOW_SIZE must stay equal to 2**MAX_LOG2_WINDOW */
`ifndef WINDOW_SETTINGS_SVH
`define WINDOW_SETTINGS_SVH

//////////////////////////////
// Settings bus addresses
//////////////////////////////

// 129 and 130 belong to the config bus of the wrapper
`define SR_WINDOW_SIZE 8'd131
`define SR_READBACK 8'd255

//////////////////////////////
// Window limits
//////////////////////////////

`define MAX_LOG2_WINDOW 12
`define MAX_WINDOW_SIZE 4096

// Returned for any readback select without a register
`define RB_DEFAULT 64'h0BADC0DE0BADC0DE

`endif

// File: testbench/window_tb_checks.svh
/* LFSR and compare tasks, included inside the window block testbench.
   Expects lfsr_state to be declared in the including module */
`ifndef WINDOW_TB_CHECKS_SVH
`define WINDOW_TB_CHECKS_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(int n);
  logic [31:0] bits;
  logic        fb;
  bits = '0;
  for (int b = 0; b < n; b++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    bits = {bits[30:0], fb};
  end
  return bits;
endfunction

task automatic check_sample(string name, window_pkg::iq_t got, window_pkg::iq_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    $display("sim failed");
    $fatal(1, "%s mismatch", name);
  end
endtask

task automatic check_last(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    $display("sim failed");
    $fatal(1, "%s mismatch", name);
  end
endtask

task automatic check_rb(string name, window_pkg::rb_data_t got, window_pkg::rb_data_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    $display("sim failed");
    $fatal(1, "%s mismatch", name);
  end
endtask

`endif

// File: testbench/window_tb.sv
/* Testbench for the window block, cases run back to back from a table.
   Settings writes and coefficient loads happen only while the pipeline is empty */
`timescale 1ns/1ps
`include "window_settings.svh"

module window_tb;

  localparam int NUM_CASES = 6;
  localparam logic [1:0] PAT_RAMP = 2'd0;
  localparam logic [1:0] PAT_CONST = 2'd1;
  localparam logic [1:0] PAT_RANDOM = 2'd2;

  // One table row, a length of 0 selects the full window
  typedef struct packed {
    window_pkg::win_len_t len;
    logic [1:0]           pat;
    int                   count;
    logic                 bp;
  } case_t;

  logic                  ce_clk;
  logic                  i_rst;
  window_pkg::set_bus_t  i_set;
  window_pkg::rb_data_t  o_rb_data;
  window_pkg::cfg_beat_t i_cfg;
  logic                  i_cfg_valid;
  window_pkg::iq_t       i_sample;
  logic                  i_valid;
  logic                  o_ready;
  window_pkg::iq_t       o_sample;
  logic                  o_last;
  logic                  o_valid;
  logic                  i_ready;

  logic [31:0]           lfsr_state = 32'h628f;
  case_t                 cases [NUM_CASES];

  // Reference model state
  window_pkg::coeff_t    model_coeff [`MAX_WINDOW_SIZE];
  int                    model_len;
  int                    model_idx;
  window_pkg::iq_t       exp_sample_q [$];
  logic                  exp_last_q [$];

  `include "window_tb_checks.svh"

  window_block dut0 (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_set       (i_set),
    .o_rb_data   (o_rb_data),
    .i_cfg       (i_cfg),
    .i_cfg_valid (i_cfg_valid),
    .i_sample    (i_sample),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .o_sample    (o_sample),
    .o_last      (o_last),
    .o_valid     (o_valid),
    .i_ready     (i_ready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #2 ce_clk = ~ce_clk;
  end

  function automatic int window_length(window_pkg::win_len_t len);
    return (len == '0) ? `MAX_WINDOW_SIZE : int'(len);
  endfunction

  // Arithmetic shift right by 15 of the full product, low 16 bits kept
  function automatic logic signed [15:0] scale_q15(logic signed [15:0] x,
                                                   window_pkg::coeff_t c);
    logic signed [31:0] p;
    logic signed [31:0] s;
    p = x * c;
    s = p >>> 15;
    return s[15:0];
  endfunction

  function automatic window_pkg::coeff_t pick_coeff(logic [1:0] pat, int k);
    if (pat == PAT_RAMP) begin
      return window_pkg::coeff_t'(k * 8 - 16384);
    end else if (pat == PAT_CONST) begin
      return 16'h7fff;
    end
    return window_pkg::coeff_t'(lfsr_bits(16));
  endfunction

  task automatic push_expected(window_pkg::iq_t s);
    window_pkg::iq_t e;
    logic            last;
    e.i = scale_q15(s.i, model_coeff[model_idx]);
    e.q = scale_q15(s.q, model_coeff[model_idx]);
    last = (model_idx == model_len - 1);
    exp_sample_q.push_back(e);
    exp_last_q.push_back(last);
    model_idx = last ? 0 : model_idx + 1;
  endtask

  task automatic write_setting(logic [7:0] addr, logic [31:0] data);
    i_set <= '{stb: 1'b1, addr: addr, data: data};
    @(posedge ce_clk);
    i_set <= '0;
  endtask

  // Select written at one edge, word valid before the next
  task automatic read_back(logic [31:0] sel, window_pkg::rb_data_t exp);
    write_setting(`SR_READBACK, sel);
    @(posedge ce_clk);
    check_rb("o_rb_data", o_rb_data, exp);
  endtask

  task automatic load_coeffs(case_t c);
    window_pkg::coeff_t w;
    int                 n;
    n = window_length(c.len);
    for (int k = 0; k < n; k++) begin
      w = pick_coeff(c.pat, k);
      model_coeff[k] = w;
      i_cfg <= '{coeff: w, last: (k == n - 1)};
      i_cfg_valid <= 1'b1;
      @(posedge ce_clk);
    end
    i_cfg_valid <= 1'b0;
  endtask

  //////////////////////////////
  // Stream driver and monitor
  //////////////////////////////

  task automatic drive_samples(case_t c);
    window_pkg::iq_t s;
    for (int k = 0; k < c.count; k++) begin
      while (c.bp && lfsr_bits(2) == 32'd0) begin
        i_valid <= 1'b0;
        @(posedge ce_clk);
      end
      s = window_pkg::iq_t'(lfsr_bits(32));
      i_valid <= 1'b1;
      i_sample <= s;
      @(posedge ce_clk);
      while (!o_ready) begin
        @(posedge ce_clk);
      end
      push_expected(s);
    end
    i_valid <= 1'b0;
  endtask

  task automatic collect_samples(case_t c);
    window_pkg::iq_t held_sample;
    logic            held_last;
    logic            held_valid;
    int              got;
    got = 0;
    held_valid = 1'b0;
    i_ready <= 1'b1;
    while (got < c.count) begin
      @(posedge ce_clk);
      if (held_valid) begin
        if (!o_valid) begin
          $display("sim failed");
          $fatal(1, "output valid dropped while the output was stalled");
        end
        check_sample("o_sample (stalled)", o_sample, held_sample);
        check_last("o_last (stalled)", o_last, held_last);
      end
      if (o_valid && i_ready) begin
        if (exp_sample_q.size() == 0) begin
          $display("sim failed");
          $fatal(1, "output sample arrived with no matching input");
        end
        check_sample("o_sample", o_sample, exp_sample_q.pop_front());
        check_last("o_last", o_last, exp_last_q.pop_front());
        got++;
      end
      held_valid = o_valid && !i_ready;
      held_sample = o_sample;
      held_last = o_last;
      i_ready <= c.bp ? (lfsr_bits(2) != 32'd0) : 1'b1;
    end
    i_ready <= 1'b1;
  endtask

  // A drained pipeline must not raise valid again
  task automatic expect_idle(int cycles);
    repeat (cycles) begin
      @(posedge ce_clk);
      if (o_valid) begin
        $display("sim failed");
        $fatal(1, "output valid rose with no sample in flight");
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    cases[0] = '{13'd8, PAT_RAMP, 40, 1'b0};
    cases[1] = '{13'd5, PAT_RANDOM, 37, 1'b1};
    cases[2] = '{13'd1, PAT_CONST, 12, 1'b0};
    cases[3] = '{13'd3, PAT_RANDOM, 25, 1'b1};
    cases[4] = '{13'd0, PAT_RAMP, 4100, 1'b0};
    cases[5] = '{13'd16, PAT_RANDOM, 100, 1'b1};
    i_rst <= 1'b1;
    i_set <= '0;
    i_cfg <= '0;
    i_cfg_valid <= 1'b0;
    i_sample <= '0;
    i_valid <= 1'b0;
    i_ready <= 1'b1;
    repeat (10) @(posedge ce_clk);
    i_rst <= 1'b0;
    @(posedge ce_clk);
    @(posedge ce_clk);
    check_rb("o_rb_data", o_rb_data, 64'(`MAX_WINDOW_SIZE));
    read_back(32'd1, 64'(`MAX_WINDOW_SIZE));

    for (int r = 0; r < NUM_CASES; r++) begin
      load_coeffs(cases[r]);
      write_setting(`SR_WINDOW_SIZE, 32'(cases[r].len));
      model_len = window_length(cases[r].len);
      model_idx = 0;
      read_back(32'd1, window_pkg::rb_data_t'(model_len));
      fork
        drive_samples(cases[r]);
        collect_samples(cases[r]);
      join
      expect_idle(4);
    end

    read_back(32'd6, `RB_DEFAULT);
    $display("sim passed");
    $finish;
  end

  // Budget from the table, filled at time 0
  initial begin
    longint limit_ns;
    #1;
    limit_ns = 2000;
    for (int r = 0; r < NUM_CASES; r++) begin
      limit_ns += 40 * cases[r].count + 4 * window_length(cases[r].len) + 200;
    end
    #(limit_ns);
    $display("sim failed");
    $fatal(1, "watchdog timeout, the DUT stopped making progress");
  end

endmodule
